// ==== wiscExec.f ====
+incdir+hdl
hdl/wiscPkg.sv
hdl/instrDecode.sv
hdl/aluCore.sv
hdl/resultStage.sv
hdl/execUnit.sv
verification/clockGen.sv
verification/execUnitTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLIST     ?= wiscExec.f
TOP       ?= execUnitTb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/execUnitTb.sv ====
// Execute stage testbench with directed tests, reference model, scoreboard and watchdog
`include "wisc_config.svh"

module execUnitTb;
    timeunit 1ns;
    timeprecision 1ps;
    import wiscPkg::*;

    // Instructions sent over all tests
    localparam int numInstr = 7 + 5 + 4 * 16 * 2 + 9 + 17 + 200 + 10;

    logic clk;
    logic arstN;
    logic inValid;
    wiscInstr_t instr;
    logic [`WORD_WIDTH-1:0] rsData;
    logic [`WORD_WIDTH-1:0] rtData;
    logic outReady = 1'b1;
    logic inReady;
    logic outValid;
    logic [`WORD_WIDTH-1:0] result;
    logic [`REG_IDX_WIDTH-1:0] rdIdx;
    logic zero;
    logic ofl;
    logic illegal;

    logic gapMode = 1'b0;
    logic latencyCheck = 1'b1;
    int cyc = 0;
    logic [`WORD_WIDTH-1:0] expResult[$];
    logic expZero[$];
    logic expOfl[$];
    logic expIllegal[$];
    logic [`REG_IDX_WIDTH-1:0] expRd[$];
    int expEdge[$];
    logic [4:0] legalOpc[15] = '{5'b01000, 5'b01001, 5'b01010, 5'b01011, 5'b10100,
        5'b10101, 5'b10110, 5'b10111, 5'b11001, 5'b11010, 5'b11011, 5'b11100,
        5'b11101, 5'b11110, 5'b11111};

    clockGen uClk (.clk(clk), .arstN(arstN));

    execUnit dut (.clk(clk), .arstN(arstN), .inValid(inValid), .instr(instr),
        .rsData(rsData), .rtData(rtData), .outReady(outReady), .inReady(inReady),
        .outValid(outValid), .result(result), .rdIdx(rdIdx), .zero(zero), .ofl(ofl),
        .illegal(illegal));

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic checkWord(input string name, input logic [`WORD_WIDTH-1:0] got,
                             input logic [`WORD_WIDTH-1:0] exp);
        if (got !== exp)
            failNow($sformatf("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp));
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp)
            failNow($sformatf("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp));
    endtask

    task automatic checkIdx(input string name, input logic [`REG_IDX_WIDTH-1:0] got,
                            input logic [`REG_IDX_WIDTH-1:0] exp);
        if (got !== exp)
            failNow($sformatf("MISMATCH at %0t: %s got %0d expected %0d", $time, name, got, exp));
    endtask

    function automatic logic isLegal(input logic [4:0] opc);
        foreach (legalOpc[i]) begin
            if (legalOpc[i] == opc)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // Kind 00 rotate left, 01 shift left, 10 rotate right, 11 shift right
    function automatic logic [`WORD_WIDTH-1:0] shiftRef(input logic [1:0] kind,
        input logic [`WORD_WIDTH-1:0] a, input logic [`SHAMT_WIDTH-1:0] amt);
        logic [2*`WORD_WIDTH-1:0] t;
        case (kind)
            2'b00: t = {a, a} << amt;
            2'b10: t = {a, a} >> amt;
            default: t = '0;
        endcase
        case (kind)
            2'b00: return t[2*`WORD_WIDTH-1:`WORD_WIDTH];
            2'b01: return a << amt;
            2'b10: return t[`WORD_WIDTH-1:0];
            default: return a >> amt;
        endcase
    endfunction

    function automatic void model(input logic [`WORD_WIDTH-1:0] w,
        input logic [`WORD_WIDTH-1:0] a, input logic [`WORD_WIDTH-1:0] rt,
        output logic [`WORD_WIDTH-1:0] r, output logic o, output logic ill,
        output logic [`REG_IDX_WIDTH-1:0] rd);
        logic [4:0] opc;
        logic [`WORD_WIDTH-1:0] b;
        logic [`WORD_WIDTH:0] s;
        logic [1:0] kind;
        logic rFmt;
        opc = w[15:11];
        r = '0;
        o = 1'b0;
        ill = !isLegal(opc);
        rFmt = !ill && (opc[4:3] == 2'b11);
        b = rt;
        if (opc == 5'b01000 || opc == 5'b01001)
            b = {{(`WORD_WIDTH-5){w[4]}}, w[4:0]};
        else if (opc == 5'b01010 || opc == 5'b01011 || opc[4:2] == 3'b101)
            b = {{(`WORD_WIDTH-5){1'b0}}, w[4:0]};
        kind = (opc[4:1] == 4'b1101) ? w[1:0] : opc[1:0];
        s = {1'b0, a} + {1'b0, b};
        if (opc[4:2] == 3'b010 || opc == 5'b11011) begin
            case (kind)
                2'b00: begin
                    r = s[`WORD_WIDTH-1:0];
                    o = (a[15] == b[15]) && (r[15] != a[15]);
                end
                2'b01: begin
                    r = b - a;              // Second operand minus first
                    o = (a[15] != b[15]) && (r[15] != b[15]);
                end
                2'b10: r = a ^ b;
                default: r = a & ~b;
            endcase
        end else if (opc[4:2] == 3'b101 || opc == 5'b11010) begin
            r = shiftRef(kind, a, b[`SHAMT_WIDTH-1:0]);
        end else if (opc == 5'b11001) begin
            for (int i = 0; i < `WORD_WIDTH; i++) r[i] = a[`WORD_WIDTH-1-i];
        end else if (opc == 5'b11100) r = {15'b0, a == b};
        else if (opc == 5'b11101) r = {15'b0, $signed(a) < $signed(b)};
        else if (opc == 5'b11110) r = {15'b0, $signed(a) <= $signed(b)};
        else if (opc == 5'b11111) r = {15'b0, s[`WORD_WIDTH]};
        rd = rFmt ? w[4:2] : w[7:5];
    endfunction

    function automatic logic [15:0] encR(input logic [4:0] opc, input logic [2:0] rd,
                                         input logic [1:0] funct);
        return {opc, 3'($urandom), 3'($urandom), rd, funct};
    endfunction

    function automatic logic [15:0] encI(input logic [4:0] opc, input logic [2:0] rd,
                                         input logic [4:0] imm);
        return {opc, 3'($urandom), rd, imm};
    endfunction

    // Called and returns 2 ns after a rising edge
    task automatic sendInstr(input logic [15:0] w, input logic [15:0] a, input logic [15:0] rt);
        logic [`WORD_WIDTH-1:0] r;
        logic o;
        logic ill;
        logic [`REG_IDX_WIDTH-1:0] rd;
        instr = w;
        rsData = a;
        rtData = rt;
        inValid = 1'b1;
        @(negedge clk);
        while (!inReady) @(negedge clk);
        model(w, a, rt, r, o, ill, rd);
        expResult.push_back(r);
        expZero.push_back(r == '0);
        expOfl.push_back(o);
        expIllegal.push_back(ill);
        expRd.push_back(rd);
        expEdge.push_back(cyc + 1);         // Edge that takes the instruction
        @(posedge clk);
        #2 inValid = 1'b0;
    endtask

    task automatic waitDrain();
        int n;
        n = 0;
        while (expResult.size() != 0) begin
            @(posedge clk);
            n++;
            if (n > 1000) failNow("Pipeline did not deliver all pending results");
        end
        @(posedge clk);
        #2;
    endtask

    task automatic testRegArith();
        sendInstr(encR(5'b11011, 3'd1, 2'b00), 16'h7FFF, 16'h0001);
        sendInstr(encR(5'b11011, 3'd2, 2'b00), 16'h0001, 16'hFFFF);
        sendInstr(encR(5'b11011, 3'd3, 2'b01), 16'h8000, 16'h0001);
        sendInstr(encR(5'b11011, 3'd4, 2'b01), 16'h1234, 16'h1234);
        sendInstr(encR(5'b11011, 3'd5, 2'b10), 16'h5A5A, 16'h5A5A);
        sendInstr(encR(5'b11011, 3'd6, 2'b10), 16'h1234, 16'h00FF);
        sendInstr(encR(5'b11011, 3'd7, 2'b11), 16'hF0F0, 16'hFF00);
        waitDrain();
    endtask

    task automatic testImmArith();
        sendInstr(encI(5'b01000, 3'd1, 5'h1F), 16'h0010, 16'hAAAA);
        sendInstr(encI(5'b01010, 3'd2, 5'h1F), 16'h0000, 16'hAAAA);
        sendInstr(encI(5'b01001, 3'd3, 5'h10), 16'h0003, 16'h5555);
        sendInstr(encI(5'b01011, 3'd4, 5'h0F), 16'hFFFF, 16'h0000);
        sendInstr(encI(5'b01000, 3'd5, 5'h01), 16'h7FFF, 16'h0000);
        waitDrain();
    endtask

    task automatic testShifts();
        for (int k = 0; k < 4; k++) begin
            for (int amt = 0; amt < 16; amt++) begin
                sendInstr(encI({3'b101, 2'(k)}, 3'(amt), {1'($urandom), 4'(amt)}),
                          16'($urandom), 16'($urandom));
                sendInstr(encR(5'b11010, 3'(amt), 2'(k)), 16'($urandom),
                          {12'($urandom), 4'(amt)});
            end
        end
        waitDrain();
    endtask

    task automatic testCompare();
        sendInstr(encR(5'b11001, 3'd1, 2'b00), 16'h1234, 16'h0000);
        sendInstr(encR(5'b11100, 3'd2, 2'b00), 16'hBEEF, 16'hBEEF);
        sendInstr(encR(5'b11100, 3'd3, 2'b00), 16'hBEEF, 16'hBEEE);
        sendInstr(encR(5'b11101, 3'd4, 2'b00), 16'hFFFE, 16'h0001);
        sendInstr(encR(5'b11101, 3'd5, 2'b00), 16'h0001, 16'hFFFE);
        sendInstr(encR(5'b11110, 3'd6, 2'b00), 16'h8000, 16'h8000);
        sendInstr(encR(5'b11110, 3'd7, 2'b00), 16'h8000, 16'h7FFF);
        sendInstr(encR(5'b11111, 3'd0, 2'b00), 16'hFFFF, 16'h0001);
        sendInstr(encR(5'b11111, 3'd1, 2'b00), 16'h0001, 16'h0001);
        waitDrain();
    endtask

    task automatic testIllegal();
        for (int o = 0; o < 32; o++) begin
            if (!isLegal(5'(o)))
                sendInstr(encI(5'(o), 3'(o), 5'($urandom)), 16'($urandom), 16'($urandom));
        end
        waitDrain();
    endtask

    task automatic testStream();
        latencyCheck = 1'b0;
        gapMode = 1'b1;
        for (int i = 0; i < 200; i++) begin
            sendInstr(encR(legalOpc[$urandom % 15], 3'($urandom), 2'($urandom)),
                      16'($urandom), 16'($urandom));
        end
        waitDrain();
        gapMode = 1'b0;
        @(posedge clk);
        #2 latencyCheck = 1'b1;             // outReady is high again
        for (int i = 0; i < 10; i++) begin
            sendInstr(encR(legalOpc[$urandom % 15], 3'($urandom), 2'($urandom)),
                      16'($urandom), 16'($urandom));
        end
        waitDrain();
    endtask

    always @(posedge clk) cyc <= cyc + 1;

    always @(posedge clk) begin
        #2 outReady = gapMode ? ($urandom % 4 != 0) : 1'b1;
    end

    // Output side scoreboard sampled before the transfer edge
    always @(negedge clk) begin
        if (arstN && outValid && outReady) begin
            if (expResult.size() == 0) begin
                failNow("Output handshake seen with no instruction pending");
            end else begin
                checkWord("result", result, expResult.pop_front());
                checkFlag("zero", zero, expZero.pop_front());
                checkFlag("ofl", ofl, expOfl.pop_front());
                checkFlag("illegal", illegal, expIllegal.pop_front());
                checkIdx("rdIdx", rdIdx, expRd.pop_front());
                if (latencyCheck && (cyc + 1 - expEdge[0] != 2))
                    failNow($sformatf("Result left %0d cycles after acceptance instead of 2",
                                      cyc + 1 - expEdge[0]));
                void'(expEdge.pop_front());
            end
        end
    end

    initial begin
        repeat (numInstr * 20 + 100) @(posedge clk);
        failNow("Watchdog expired before the tests finished");
    end

    initial begin
        void'($urandom(84));
        inValid = 1'b0;
        instr = '0;
        rsData = '0;
        rtData = '0;
        @(posedge arstN);
        @(posedge clk);
        #2;
        if (!inReady || outValid) failNow("Handshake outputs wrong after reset");
        testRegArith();
        testImmArith();
        testShifts();
        testCompare();
        testIllegal();
        testStream();
        $display("Everything OK");
        $finish;
    end

endmodule

// ==== verification/clockGen.sv ====
// Testbench clock and reset source with a 40 ns clock and reset held for 4 cycles
module clockGen (
    output logic clk,
    output logic arstN
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int halfPeriod = 20;

    initial begin
        clk = 1'b0;
        forever #halfPeriod clk = ~clk;
    end

    initial begin
        arstN = 1'b0;
        repeat (4) @(posedge clk);
        #2 arstN = 1'b1;                    // Released off the edge
    end

endmodule

// ==== hdl/execUnit.sv ====
// Execute stage top joining decode register, ALU and result register
`include "wisc_config.svh"

module execUnit (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      inValid,
    input  wiscPkg::wiscInstr_t       instr,
    input  logic [`WORD_WIDTH-1:0]    rsData,
    input  logic [`WORD_WIDTH-1:0]    rtData,
    input  logic                      outReady,
    output logic                      inReady,
    output logic                      outValid,
    output logic [`WORD_WIDTH-1:0]    result,
    output logic [`REG_IDX_WIDTH-1:0] rdIdx,
    output logic                      zero,
    output logic                      ofl,
    output logic                      illegal
);
    import wiscPkg::*;

    logic                      decValid;
    logic                      decReady;
    aluOp_t                    aluOp;
    logic [`WORD_WIDTH-1:0]    opA;
    logic [`WORD_WIDTH-1:0]    opB;
    logic [`REG_IDX_WIDTH-1:0] decRdIdx;
    logic                      decIllegal;
    logic [`WORD_WIDTH-1:0]    aluValue;
    logic                      aluOfl;

    instrDecode uDecode (.clk(clk), .arstN(arstN), .inValid(inValid), .instr(instr),
        .rsData(rsData), .rtData(rtData), .decReady(decReady), .inReady(inReady),
        .decValid(decValid), .aluOp(aluOp), .opA(opA), .opB(opB), .rdIdx(decRdIdx),
        .illegal(decIllegal));

    aluCore uAlu (.aluOp(aluOp), .opA(opA), .opB(opB), .value(aluValue), .ofl(aluOfl));

    resultStage uResult (.clk(clk), .arstN(arstN), .decValid(decValid), .value(aluValue),
        .ofl(aluOfl), .rdIdx(decRdIdx), .illegal(decIllegal), .outReady(outReady),
        .decReady(decReady), .outValid(outValid), .result(result), .rdIdxOut(rdIdx),
        .zero(zero), .oflOut(ofl), .illegalOut(illegal));

endmodule

// ==== hdl/resultStage.sv ====
// Output register holding result, zero flag and status under back-pressure
`include "wisc_config.svh"

module resultStage (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      decValid,
    input  logic [`WORD_WIDTH-1:0]    value,
    input  logic                      ofl,
    input  logic [`REG_IDX_WIDTH-1:0] rdIdx,
    input  logic                      illegal,
    input  logic                      outReady,
    output logic                      decReady,
    output logic                      outValid,
    output logic [`WORD_WIDTH-1:0]    result,
    output logic [`REG_IDX_WIDTH-1:0] rdIdxOut,
    output logic                      zero,
    output logic                      oflOut,
    output logic                      illegalOut
);

    logic load;

    assign decReady = !outValid || outReady;
    assign load     = decValid && decReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else if (load) begin
            outValid <= 1'b1;
        end else if (outReady) begin
            outValid <= 1'b0;               // Taken, nothing new behind it
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            result     <= value;
            zero       <= ~|value;
            oflOut     <= ofl;
            rdIdxOut   <= rdIdx;
            illegalOut <= illegal;
        end
    end

    outHoldCheck: assert property (@(posedge clk) disable iff (!arstN)
        outValid && !outReady |=> outValid && $stable(result));

endmodule

// ==== hdl/aluCore.sv ====
// Combinational ALU with shared adder, barrel shifter, bit reverse and signed compares
`include "wisc_config.svh"

module aluCore (
    input  wiscPkg::aluOp_t        aluOp,
    input  logic [`WORD_WIDTH-1:0] opA,
    input  logic [`WORD_WIDTH-1:0] opB,
    output logic [`WORD_WIDTH-1:0] value,
    output logic                   ofl
);
    import wiscPkg::*;

    logic                    isAdd;
    logic                    isSub;
    logic [`WORD_WIDTH-1:0]  addX;
    logic [`WORD_WIDTH:0]    sum;
    logic                    sumOfl;
    logic [`SHAMT_WIDTH-1:0] shAmt;
    logic                    shRight;
    logic                    shRotate;
    logic [`WORD_WIDTH-1:0]  shIn;
    logic [`WORD_WIDTH-1:0]  shStage;
    logic [`WORD_WIDTH-1:0]  shOut;
    logic [`WORD_WIDTH-1:0]  revA;

    function automatic logic [`WORD_WIDTH-1:0] bitRev(input logic [`WORD_WIDTH-1:0] x);
        logic [`WORD_WIDTH-1:0] r;
        for (int b = 0; b < `WORD_WIDTH; b++) begin
            r[b] = x[`WORD_WIDTH-1-b];
        end
        return r;
    endfunction

    assign isAdd = (aluOp == opAdd) || (aluOp == opAddi);
    assign isSub = (aluOp == opSub) || (aluOp == opSubi);

    // Subtract forms B + ~A + 1 to give B minus A
    assign addX   = isSub ? ~opA : opA;
    assign sum    = {1'b0, opB} + {1'b0, addX} + {{`WORD_WIDTH{1'b0}}, isSub};
    assign sumOfl = (addX[`WORD_WIDTH-1] == opB[`WORD_WIDTH-1])
                    && (sum[`WORD_WIDTH-1] != opB[`WORD_WIDTH-1]);

    assign shAmt    = opB[`SHAMT_WIDTH-1:0];
    assign shRight  = (aluOp == opRor) || (aluOp == opRori)
                      || (aluOp == opSrl) || (aluOp == opSrli);
    assign shRotate = (aluOp == opRol) || (aluOp == opRoli)
                      || (aluOp == opRor) || (aluOp == opRori);
    assign revA     = bitRev(opA);
    assign shIn     = shRight ? revA : opA; // Right shifts run on the reversed word

    // Four left-shift levels of 1, 2, 4 and 8 bits
    always_comb begin
        shStage = shIn;
        for (int k = 0; k < `SHAMT_WIDTH; k++) begin
            if (shAmt[k]) begin
                shStage = (shStage << (1 << k))
                          | (shRotate ? (shStage >> (`WORD_WIDTH - (1 << k)))
                                      : {`WORD_WIDTH{1'b0}});
            end
        end
    end

    assign shOut = shRight ? bitRev(shStage) : shStage;

    always_comb begin
        value = {`WORD_WIDTH{1'b0}};
        case (aluOp)
            opAdd, opAddi, opSub, opSubi:      value = sum[`WORD_WIDTH-1:0];
            opXor, opXori:                     value = opA ^ opB;
            opAndn, opAndni:                   value = opA & ~opB;
            opRol, opRoli, opSll, opSlli,
            opRor, opRori, opSrl, opSrli:      value = shOut;
            opBtr:                             value = revA;
            opSeq: value = {{(`WORD_WIDTH-1){1'b0}}, opA == opB};
            opSlt: value = {{(`WORD_WIDTH-1){1'b0}}, $signed(opA) < $signed(opB)};
            opSle: value = {{(`WORD_WIDTH-1){1'b0}}, $signed(opA) <= $signed(opB)};
            opSco: value = {{(`WORD_WIDTH-1){1'b0}}, sum[`WORD_WIDTH]}; // Unsigned carry
            default:                           value = {`WORD_WIDTH{1'b0}};
        endcase
    end

    // SCO shares the adder but never flags overflow
    assign ofl = (isAdd || isSub) && sumOfl;

    // The decode register always presents a defined operation
    always_comb begin
        aluOpKnown: assert final (!$isunknown(aluOp));
    end

endmodule

// ==== hdl/instrDecode.sv ====
// Decode register that maps opcode and funct to an ALU operation and builds operand B
`include "wisc_config.svh"

module instrDecode (
    input  logic                      clk,
    input  logic                      arstN,
    input  logic                      inValid,
    input  wiscPkg::wiscInstr_t       instr,
    input  logic [`WORD_WIDTH-1:0]    rsData,
    input  logic [`WORD_WIDTH-1:0]    rtData,
    input  logic                      decReady,
    output logic                      inReady,
    output logic                      decValid,
    output wiscPkg::aluOp_t           aluOp,
    output logic [`WORD_WIDTH-1:0]    opA,
    output logic [`WORD_WIDTH-1:0]    opB,
    output logic [`REG_IDX_WIDTH-1:0] rdIdx,
    output logic                      illegal
);
    import wiscPkg::*;

    aluOp_t                    nextOp;
    logic                      nextIllegal;
    logic                      useRFormat;
    logic [`WORD_WIDTH-1:0]    nextB;
    logic [`WORD_WIDTH-1:0]    immSext;
    logic [`WORD_WIDTH-1:0]    immZext;
    logic [`REG_IDX_WIDTH-1:0] nextRd;
    logic [4:0]                imm5;
    logic                      load;

    assign imm5    = instr.iFmt.imm5;
    assign immSext = {{(`WORD_WIDTH-5){imm5[4]}}, imm5};
    assign immZext = {{(`WORD_WIDTH-5){1'b0}}, imm5};

    always_comb begin
        nextOp      = opNop;
        nextIllegal = 1'b0;
        nextB       = rtData;
        useRFormat  = 1'b1;
        case (instr.iFmt.opcode)
            opcAddi:  begin nextOp = opAddi;  nextB = immSext; useRFormat = 1'b0; end
            opcSubi:  begin nextOp = opSubi;  nextB = immSext; useRFormat = 1'b0; end
            opcXori:  begin nextOp = opXori;  nextB = immZext; useRFormat = 1'b0; end
            opcAndni: begin nextOp = opAndni; nextB = immZext; useRFormat = 1'b0; end
            opcRoli:  begin nextOp = opRoli;  nextB = immZext; useRFormat = 1'b0; end
            opcSlli:  begin nextOp = opSlli;  nextB = immZext; useRFormat = 1'b0; end
            opcRori:  begin nextOp = opRori;  nextB = immZext; useRFormat = 1'b0; end
            opcSrli:  begin nextOp = opSrli;  nextB = immZext; useRFormat = 1'b0; end
            opcBtr:   nextOp = opBtr;
            opcShiftReg: begin
                case (instr.rFmt.funct)
                    2'b00:   nextOp = opRol;
                    2'b01:   nextOp = opSll;
                    2'b10:   nextOp = opRor;
                    default: nextOp = opSrl;
                endcase
            end
            opcArithReg: begin
                case (instr.rFmt.funct)
                    2'b00:   nextOp = opAdd;
                    2'b01:   nextOp = opSub;
                    2'b10:   nextOp = opXor;
                    default: nextOp = opAndn;
                endcase
            end
            opcSeq:   nextOp = opSeq;
            opcSlt:   nextOp = opSlt;
            opcSle:   nextOp = opSle;
            opcSco:   nextOp = opSco;
            default: begin
                nextIllegal = 1'b1;         // Jumps, branches, memory, LBI, NOP
                useRFormat  = 1'b0;
            end
        endcase
    end

    assign nextRd  = useRFormat ? instr.rFmt.rd : instr.iFmt.rd;
    assign inReady = !decValid || decReady; // Empty, or drained this cycle
    assign load    = inValid && inReady;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            decValid <= 1'b0;
            aluOp    <= opNop;
            illegal  <= 1'b0;
        end else if (load) begin
            decValid <= 1'b1;
            aluOp    <= nextOp;
            illegal  <= nextIllegal;
        end else if (decReady) begin
            decValid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            opA   <= rsData;
            opB   <= nextB;
            rdIdx <= nextRd;
        end
    end

    // A stalled decode entry must reach the ALU unchanged
    decHoldCheck: assert property (@(posedge clk) disable iff (!arstN)
        decValid && !decReady |=> decValid && $stable(aluOp) && $stable(opA)
            && $stable(opB) && $stable(rdIdx) && $stable(illegal));

endmodule

// ==== hdl/wiscPkg.sv ====
// Execute stage types for instruction formats, major opcodes and ALU operations
`include "wisc_config.svh"

package wiscPkg;

    typedef logic [4:0] opcode_t;

    // Major opcodes handled by the execute stage
    localparam opcode_t opcAddi     = 5'b01000;
    localparam opcode_t opcSubi     = 5'b01001;
    localparam opcode_t opcXori     = 5'b01010;
    localparam opcode_t opcAndni    = 5'b01011;
    localparam opcode_t opcRoli     = 5'b10100;
    localparam opcode_t opcSlli     = 5'b10101;
    localparam opcode_t opcRori     = 5'b10110;
    localparam opcode_t opcSrli     = 5'b10111;
    localparam opcode_t opcBtr      = 5'b11001;
    localparam opcode_t opcShiftReg = 5'b11010; // Shift selected by funct
    localparam opcode_t opcArithReg = 5'b11011; // Arithmetic selected by funct
    localparam opcode_t opcSeq      = 5'b11100;
    localparam opcode_t opcSlt      = 5'b11101;
    localparam opcode_t opcSle      = 5'b11110;
    localparam opcode_t opcSco      = 5'b11111;

    typedef struct packed {
        opcode_t                   opcode;
        logic [`REG_IDX_WIDTH-1:0] rs;
        logic [`REG_IDX_WIDTH-1:0] rt;
        logic [`REG_IDX_WIDTH-1:0] rd;     // Bits 4:2
        logic [1:0]                funct;
    } rFormat_t;

    typedef struct packed {
        opcode_t                   opcode;
        logic [`REG_IDX_WIDTH-1:0] rs;
        logic [`REG_IDX_WIDTH-1:0] rd;     // Bits 7:5
        logic [4:0]                imm5;
    } iFormat_t;

    // Same word, two field layouts
    typedef union packed {
        rFormat_t rFmt;
        iFormat_t iFmt;
    } wiscInstr_t;

    typedef enum logic [4:0] {
        opNop,
        opAddi, opSubi, opXori, opAndni,
        opRoli, opSlli, opRori, opSrli,
        opAdd, opSub, opXor, opAndn,
        opRol, opSll, opRor, opSrl,
        opBtr,
        opSeq, opSlt, opSle, opSco
    } aluOp_t;

endpackage

// ==== hdl/wisc_config.svh ====
// Execute stage configuration with data, shift amount and register index widths
`ifndef WISC_CONFIG_SVH
`define WISC_CONFIG_SVH

// One data word
`define WORD_WIDTH 16

`define SHAMT_WIDTH 4   // Low bits of operand B used as shift amount

`define REG_IDX_WIDTH 3 // Eight architectural registers

`endif
